//--- verilog/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

//////////////////////////////////////////////////
// Fetch stage sizes
//////////////////////////////////////////////////

`define XLEN_WIDTH        32            // Address and instruction width

`define GSHARE_GHSR_WIDTH 8             // History length, also PHT index bits

`define BTB_INDEX_WIDTH   4             // 16 BTB entries

//////////////////////////////////////////////////
// Reset state
//////////////////////////////////////////////////

`define PC_INIT           32'h0000_0000 // First fetch address

`endif

//--- verilog/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

   //////////////////////////////////////////////////
   // Datapath words
   //////////////////////////////////////////////////

   typedef logic [`XLEN_WIDTH-1:0] addr_t;         // Byte address
   typedef logic [`XLEN_WIDTH-1:0] instr_t;        // Raw instruction word

   //////////////////////////////////////////////////
   // Direction predictor
   //////////////////////////////////////////////////

   typedef logic [`GSHARE_GHSR_WIDTH-1:0] ghsr_t;  // Global history, newest in bit 0

   // Two-bit saturating counter, upper bit is the prediction
   typedef logic [1:0] counter_t;

   localparam counter_t CNT_STRONG_NT = 2'b00;     // Saturation floor
   localparam counter_t CNT_WEAK_NT   = 2'b01;     // Reset value
   localparam counter_t CNT_STRONG_T  = 2'b11;     // Saturation ceiling

endpackage

//--- verilog/pc_counter.sv
`timescale 1ns/10ps

`include "fetch_settings.svh"

module pc_counter (
   input  logic             clk,
   input  logic             reset_n,
   input  logic             stall,          // Hold current fetch address
   input  logic             flush,          // Redirect strobe from execute
   input  fetch_pkg::addr_t flush_target,   // Resolved branch target
   input  logic             predict_taken,  // Already gated with memory ready
   input  fetch_pkg::addr_t predict_pc,     // Predicted target
   output fetch_pkg::addr_t pc              // Slot 0 fetch address
);

   //////////////////////////////////////////////////
   // Next fetch address
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         pc <= `PC_INIT;                      // Restart vector
      end else if (flush) begin
         pc <= flush_target;                  // Mispredict wins over all
      end else if (stall) begin
         pc <= pc;                            // Decode is full
      end else if (predict_taken) begin
         pc <= predict_pc;                    // Follow taken prediction
      end else begin
         pc <= pc + `XLEN_WIDTH'd8;           // Two words per cycle
      end
   end

   // Flush and prediction targets come from outside, so the register
   // itself is where a misaligned address would first show up
   a_pc_aligned : assert property (@(posedge clk) disable iff (!reset_n)
      pc[1:0] == 2'b00);

endmodule

//--- verilog/btb.sv
`timescale 1ns/10ps

`include "fetch_settings.svh"

module btb (
   input  logic             clk,
   input  logic             reset_n,
   input  fetch_pkg::addr_t rd0_pc,       // Slot 0 lookup address
   input  fetch_pkg::addr_t rd1_pc,       // Slot 1 lookup address
   output logic             rd0_hit,
   output fetch_pkg::addr_t rd0_target,
   output logic             rd1_hit,
   output fetch_pkg::addr_t rd1_target,
   input  logic             upd_valid,    // Resolved branch strobe
   input  logic             upd_taken,    // Resolved direction
   input  fetch_pkg::addr_t upd_addr,     // Branch address
   input  fetch_pkg::addr_t upd_target    // Branch target
);

   localparam int ENTRIES   = 1 << `BTB_INDEX_WIDTH;
   localparam int IDX_LSB   = 2;                        // Skip byte offset
   localparam int IDX_MSB   = `BTB_INDEX_WIDTH + 1;
   localparam int TAG_WIDTH = `XLEN_WIDTH - `BTB_INDEX_WIDTH - 2;

   //////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////

   logic [ENTRIES-1:0]   entry_valid;                   // Cleared on reset
   logic [TAG_WIDTH-1:0] entry_tag    [ENTRIES];        // Upper address bits
   fetch_pkg::addr_t     entry_target [ENTRIES];        // Predicted target

   logic [`BTB_INDEX_WIDTH-1:0] rd0_idx;
   logic [`BTB_INDEX_WIDTH-1:0] rd1_idx;
   logic [`BTB_INDEX_WIDTH-1:0] upd_idx;
   logic [TAG_WIDTH-1:0]        rd0_tag;
   logic [TAG_WIDTH-1:0]        rd1_tag;
   logic [TAG_WIDTH-1:0]        upd_tag;
   logic                        upd_tag_match;          // Update hits its own entry

   //////////////////////////////////////////////////
   // Lookup, both slots
   //////////////////////////////////////////////////

   assign rd0_idx = rd0_pc[IDX_MSB:IDX_LSB];
   assign rd1_idx = rd1_pc[IDX_MSB:IDX_LSB];
   assign rd0_tag = rd0_pc[`XLEN_WIDTH-1:IDX_MSB+1];
   assign rd1_tag = rd1_pc[`XLEN_WIDTH-1:IDX_MSB+1];

   assign rd0_hit    = entry_valid[rd0_idx] && (entry_tag[rd0_idx] == rd0_tag);
   assign rd1_hit    = entry_valid[rd1_idx] && (entry_tag[rd1_idx] == rd1_tag);
   assign rd0_target = entry_target[rd0_idx];
   assign rd1_target = entry_target[rd1_idx];

   //////////////////////////////////////////////////
   // Update from execute
   //////////////////////////////////////////////////

   assign upd_idx       = upd_addr[IDX_MSB:IDX_LSB];
   assign upd_tag       = upd_addr[`XLEN_WIDTH-1:IDX_MSB+1];
   assign upd_tag_match = (entry_tag[upd_idx] == upd_tag);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         entry_valid <= '0;                             // Empty table
      end else if (upd_valid) begin
         if (upd_taken) begin
            entry_valid[upd_idx] <= 1'b1;               // Allocate or refresh
         end else if (upd_tag_match) begin
            entry_valid[upd_idx] <= 1'b0;               // Drop not-taken branch
         end
      end
   end

   always_ff @(posedge clk) begin
      if (upd_valid && upd_taken) begin
         entry_tag[upd_idx]    <= upd_tag;              // Replaces any alias
         entry_target[upd_idx] <= upd_target;
      end
   end

   a_upd_aligned : assert property (@(posedge clk) disable iff (!reset_n)
      upd_valid |-> upd_addr[1:0] == 2'b00);

endmodule

//--- verilog/gshare.sv
`timescale 1ns/10ps

`include "fetch_settings.svh"

module gshare (
   input  logic             clk,
   input  logic             reset_n,
   input  fetch_pkg::addr_t rd0_pc,       // Slot 0 fetch address
   input  fetch_pkg::addr_t rd1_pc,       // Slot 1 fetch address
   output logic             rd0_taken,    // Slot 0 direction
   output logic             rd1_taken,    // Slot 1 direction
   output fetch_pkg::ghsr_t ghsr,         // History used for this fetch
   input  logic             upd_valid,    // Resolved branch strobe
   input  logic             upd_taken,    // Resolved direction
   input  fetch_pkg::addr_t upd_addr,     // Branch address
   input  fetch_pkg::ghsr_t upd_ghsr      // History at prediction time
);

   localparam int PHT_ENTRIES = 1 << `GSHARE_GHSR_WIDTH;
   localparam int IDX_LSB     = 2;                      // Word address
   localparam int IDX_MSB     = `GSHARE_GHSR_WIDTH + 1;

   //////////////////////////////////////////////////
   // Pattern table and indices
   //////////////////////////////////////////////////

   fetch_pkg::counter_t pht [PHT_ENTRIES];              // One counter per index

   fetch_pkg::ghsr_t    rd0_idx;
   fetch_pkg::ghsr_t    rd1_idx;
   fetch_pkg::ghsr_t    upd_idx;
   fetch_pkg::counter_t upd_cnt;                        // Counter before update
   fetch_pkg::counter_t upd_cnt_next;                   // Counter after update

   // Fetch side hashes with the live history
   assign rd0_idx = rd0_pc[IDX_MSB:IDX_LSB] ^ ghsr;
   assign rd1_idx = rd1_pc[IDX_MSB:IDX_LSB] ^ ghsr;

   assign rd0_taken = pht[rd0_idx][1];                  // MSB gives direction
   assign rd1_taken = pht[rd1_idx][1];

   // Update side hashes with the history the branch saw
   assign upd_idx = upd_addr[IDX_MSB:IDX_LSB] ^ upd_ghsr;
   assign upd_cnt = pht[upd_idx];

   //////////////////////////////////////////////////
   // Saturating counter step
   //////////////////////////////////////////////////

   always_comb begin
      upd_cnt_next = upd_cnt;
      if (upd_taken) begin
         if (upd_cnt != fetch_pkg::CNT_STRONG_T) begin
            upd_cnt_next = upd_cnt + 2'd1;              // Toward taken
         end
      end else begin
         if (upd_cnt != fetch_pkg::CNT_STRONG_NT) begin
            upd_cnt_next = upd_cnt - 2'd1;              // Toward not-taken
         end
      end
   end

   //////////////////////////////////////////////////
   // History and table state
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ghsr <= '0;                                    // No history yet
         for (int i = 0; i < PHT_ENTRIES; i++) begin
            pht[i] <= fetch_pkg::CNT_WEAK_NT;
         end
      end else if (upd_valid) begin
         ghsr         <= {ghsr[`GSHARE_GHSR_WIDTH-2:0], upd_taken}; // Shift in outcome
         pht[upd_idx] <= upd_cnt_next;
      end
   end

   // A wrapped counter would read strong-NT after a taken update or
   // strong-T after a not-taken one
   a_cnt_no_wrap : assert property (@(posedge clk) disable iff (!reset_n)
      upd_valid |=> pht[$past(upd_idx)] !=
         ($past(upd_taken) ? fetch_pkg::CNT_STRONG_NT : fetch_pkg::CNT_STRONG_T));

endmodule

//--- verilog/if_stage.sv
`timescale 1ns/10ps

`include "fetch_settings.svh"

module if_stage (
   input  logic              clk,
   input  logic              reset_n,
   // Instruction memory
   output logic              instr_req_valid,   // Low while stalled
   output fetch_pkg::addr_t  instr_req_pc0,
   output fetch_pkg::addr_t  instr_req_pc1,
   input  logic              resp_ready,        // Low on a miss
   input  fetch_pkg::instr_t resp_instr0,
   input  fetch_pkg::instr_t resp_instr1,
   output logic              imem_miss,
   // Execute resolution
   input  logic              ex_branch_valid,
   input  logic              ex_branch_taken,
   input  fetch_pkg::addr_t  ex_branch_addr,
   input  fetch_pkg::addr_t  ex_branch_target,
   input  fetch_pkg::ghsr_t  ex_branch_ghsr,
   // Flush and stall unit
   input  logic              pc_flush,
   input  logic              pc_stall,
   // Decode, slot 0
   output logic              if_valid0,
   output fetch_pkg::addr_t  if_pc0,
   output fetch_pkg::instr_t if_instr0,
   output logic              if_pred_taken0,
   output logic              if_btb_hit0,
   output fetch_pkg::addr_t  if_btb_target0,
   output fetch_pkg::ghsr_t  if_ghsr0,
   // Decode, slot 1
   output logic              if_valid1,
   output fetch_pkg::addr_t  if_pc1,
   output fetch_pkg::instr_t if_instr1,
   output logic              if_pred_taken1,
   output logic              if_btb_hit1,
   output fetch_pkg::addr_t  if_btb_target1,
   output fetch_pkg::ghsr_t  if_ghsr1
);

   fetch_pkg::addr_t pc;
   fetch_pkg::addr_t pc_plus4;          // Slot 1 address
   logic             btb_hit0;
   logic             btb_hit1;
   fetch_pkg::addr_t btb_target0;
   fetch_pkg::addr_t btb_target1;
   logic             gs_taken0;         // Direction only, ignores BTB
   logic             gs_taken1;
   fetch_pkg::ghsr_t gs_ghsr;
   logic             slot0_taken;       // Hit and predicted taken
   logic             slot1_taken;
   logic             predict_taken;     // Gated with memory ready
   fetch_pkg::addr_t predict_pc;

   assign pc_plus4 = pc + `XLEN_WIDTH'd4;

   //////////////////////////////////////////////////
   // Next-PC prediction
   //////////////////////////////////////////////////

   assign slot0_taken = btb_hit0 && gs_taken0;
   assign slot1_taken = btb_hit1 && gs_taken1;

   always_comb begin
      if (slot0_taken) begin
         predict_pc = btb_target0;      // Older slot first
      end else if (slot1_taken) begin
         predict_pc = btb_target1;
      end else begin
         predict_pc = `PC_INIT;         // Unused by pc_counter here
      end
   end

   assign predict_taken = resp_ready && (slot0_taken || slot1_taken); // Only on valid data

   //////////////////////////////////////////////////
   // Memory request
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         instr_req_valid <= 1'b1;
      end else begin
         instr_req_valid <= !pc_stall;  // Follows stall one cycle late
      end
   end

   assign instr_req_pc0 = pc;
   assign instr_req_pc1 = pc_plus4;
   assign imem_miss     = !resp_ready;

   //////////////////////////////////////////////////
   // Decode outputs
   //////////////////////////////////////////////////

   assign if_valid0      = resp_ready;
   assign if_valid1      = resp_ready && !slot0_taken;  // Shadow of taken slot 0
   assign if_pc0         = pc;
   assign if_pc1         = pc_plus4;
   assign if_instr0      = resp_instr0;
   assign if_instr1      = resp_instr1;
   assign if_pred_taken0 = slot0_taken;
   assign if_pred_taken1 = slot1_taken;
   assign if_btb_hit0    = btb_hit0;
   assign if_btb_hit1    = btb_hit1;
   assign if_btb_target0 = btb_target0;
   assign if_btb_target1 = btb_target1;
   assign if_ghsr0       = gs_ghsr;     // Same history for both slots
   assign if_ghsr1       = gs_ghsr;

   //////////////////////////////////////////////////
   // Submodules
   //////////////////////////////////////////////////

   pc_counter u_pc_counter (
      .clk           (clk),
      .reset_n       (reset_n),
      .stall         (pc_stall),
      .flush         (pc_flush),
      .flush_target  (ex_branch_target),
      .predict_taken (predict_taken),
      .predict_pc    (predict_pc),
      .pc            (pc)
   );

   btb u_btb (
      .clk        (clk),
      .reset_n    (reset_n),
      .rd0_pc     (pc),
      .rd1_pc     (pc_plus4),
      .rd0_hit    (btb_hit0),
      .rd0_target (btb_target0),
      .rd1_hit    (btb_hit1),
      .rd1_target (btb_target1),
      .upd_valid  (ex_branch_valid),
      .upd_taken  (ex_branch_taken),
      .upd_addr   (ex_branch_addr),
      .upd_target (ex_branch_target)
   );

   gshare u_gshare (
      .clk       (clk),
      .reset_n   (reset_n),
      .rd0_pc    (pc),
      .rd1_pc    (pc_plus4),
      .rd0_taken (gs_taken0),
      .rd1_taken (gs_taken1),
      .ghsr      (gs_ghsr),
      .upd_valid (ex_branch_valid),
      .upd_taken (ex_branch_taken),
      .upd_addr  (ex_branch_addr),
      .upd_ghsr  (ex_branch_ghsr)
   );

   a_slot1_needs_slot0 : assert property (@(posedge clk) disable iff (!reset_n)
      if_valid1 |-> if_valid0);

endmodule

//--- test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
   output logic clk,
   output logic reset_n
);

   localparam int RESET_CYCLES = 10;

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                 // 8 ns period
   end

   initial begin
      reset_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset_n = 1'b1;                     // Released off the edge
   end

endmodule

//--- test/tb_if_stage.sv
`timescale 1ns/10ps

`include "fetch_settings.svh"

module tb_if_stage;

   localparam fetch_pkg::addr_t BR_ADDR    = 32'h0000_0100;    // Trained branch
   localparam fetch_pkg::addr_t BR_TARGET  = 32'h0000_0200;
   localparam fetch_pkg::addr_t FL_TARGET  = 32'h0000_0340;    // Flush destination
   localparam fetch_pkg::ghsr_t TRAIN_GHSR = 8'hFF;            // History returned by decode
   localparam int TEST_CYCLES = 10 + 1 + 20 + 30 + 12 + 18 + 9 + 7; // Reset plus each test
   localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;

   logic              clk;
   logic              reset_n;
   logic              instr_req_valid;
   fetch_pkg::addr_t  instr_req_pc0;
   fetch_pkg::addr_t  instr_req_pc1;
   logic              resp_ready;
   fetch_pkg::instr_t resp_instr0;
   fetch_pkg::instr_t resp_instr1;
   logic              imem_miss;
   logic              ex_branch_valid;
   logic              ex_branch_taken;
   fetch_pkg::addr_t  ex_branch_addr;
   fetch_pkg::addr_t  ex_branch_target;
   fetch_pkg::ghsr_t  ex_branch_ghsr;
   logic              pc_flush;
   logic              pc_stall;
   logic              if_valid0;
   fetch_pkg::addr_t  if_pc0;
   fetch_pkg::instr_t if_instr0;
   logic              if_pred_taken0;
   logic              if_btb_hit0;
   fetch_pkg::addr_t  if_btb_target0;
   fetch_pkg::ghsr_t  if_ghsr0;
   logic              if_valid1;
   fetch_pkg::addr_t  if_pc1;
   fetch_pkg::instr_t if_instr1;
   logic              if_pred_taken1;
   logic              if_btb_hit1;
   fetch_pkg::addr_t  if_btb_target1;
   fetch_pkg::ghsr_t  if_ghsr1;

   string             test_name = "reset";
   int                err_count = 0;
   int                err_at_start = 0;
   int                tests_run = 0;
   int                cycle_count = 0;
   logic              force_ready;                  // Memory always answers
   logic              track_valid;                  // BTB expectation is live
   logic              track_hit;
   fetch_pkg::addr_t  track_addr;
   fetch_pkg::addr_t  track_target;
   logic              pred_check;                   // Gshare trained taken at track_addr
   logic              reset_d = 1'b0;
   logic              exp_pc_valid = 1'b0;
   fetch_pkg::addr_t  exp_pc;                       // Next fetch address by priority rules
   fetch_pkg::ghsr_t  exp_ghsr;                     // Resolved outcomes, newest in bit 0
   logic              exp_req_valid;
   logic              taken0;
   logic              taken1;
   logic              taken_ready;
   fetch_pkg::addr_t  taken_target;
   logic [2:0]        exp_flags;                    // {imem_miss, valid0, valid1}

   tb_clock clock0 (.clk(clk), .reset_n(reset_n));

   if_stage dut0 (.*);

   //////////////////////////////////////////////////
   // Memory model
   //////////////////////////////////////////////////

   function automatic fetch_pkg::instr_t mem_word(input fetch_pkg::addr_t addr);
      return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]}; // Whole address mixed
   endfunction

   assign resp_instr0 = mem_word(instr_req_pc0);
   assign resp_instr1 = mem_word(instr_req_pc1);

   initial begin
      void'($urandom(43));
      resp_ready = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         resp_ready = force_ready || (($urandom % 4) != 0); // About one miss in four
      end
   end

   //////////////////////////////////////////////////
   // Expected values
   //////////////////////////////////////////////////

   assign taken0       = if_btb_hit0 && if_pred_taken0;
   assign taken1       = if_btb_hit1 && if_pred_taken1;
   assign taken_ready  = resp_ready && (taken0 || taken1);
   assign taken_target = taken0 ? if_btb_target0 : if_btb_target1; // Older slot first
   assign exp_flags    = resp_ready ? {1'b0, 1'b1, !taken0} : 3'b100;

   always @(posedge clk) begin
      reset_d       <= reset_n;
      exp_pc_valid  <= reset_n;
      exp_req_valid <= !reset_n || !pc_stall;
      if (!reset_n) begin
         exp_ghsr <= '0;                            // No outcomes yet
      end else if (ex_branch_valid) begin
         exp_ghsr <= {exp_ghsr[`GSHARE_GHSR_WIDTH-2:0], ex_branch_taken};
      end
      if (pc_flush) begin
         exp_pc <= ex_branch_target;                // Flush first
      end else if (pc_stall) begin
         exp_pc <= instr_req_pc0;
      end else if (taken_ready) begin
         exp_pc <= taken_target;
      end else begin
         exp_pc <= instr_req_pc0 + 32'd8;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: tests still running after %0d cycles", cycle_count);
         $display("TEST FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   a_reset_pc : assert property (@(posedge clk) reset_n && !reset_d |->
      instr_req_pc0 == `PC_INIT)
      else begin
         err_count++;
         $display("Mismatch %s reset pc expected %h actual %h", test_name,
                  `PC_INIT, $sampled(instr_req_pc0));
      end

   a_next_pc : assert property (@(posedge clk) disable iff (!reset_n)
      exp_pc_valid |-> instr_req_pc0 == exp_pc)
      else begin
         err_count++;
         $display("Mismatch %s next pc expected %h actual %h", test_name,
                  $sampled(exp_pc), $sampled(instr_req_pc0));
      end

   a_slot_pc : assert property (@(posedge clk) disable iff (!reset_n)
      if_pc0 == instr_req_pc0 && if_pc1 == instr_req_pc1 && if_pc1 == if_pc0 + 32'd4)
      else begin
         err_count++;
         $display("Mismatch %s slot 1 pc expected %h actual %h", test_name,
                  $sampled(if_pc0) + 32'd4, $sampled(if_pc1));
      end

   a_req_valid : assert property (@(posedge clk) disable iff (!reset_n)
      instr_req_valid == exp_req_valid)
      else begin
         err_count++;
         $display("Mismatch %s instr_req_valid expected %b actual %b", test_name,
                  $sampled(exp_req_valid), $sampled(instr_req_valid));
      end

   a_flags : assert property (@(posedge clk) disable iff (!reset_n)
      {imem_miss, if_valid0, if_valid1} == exp_flags)
      else begin
         err_count++;
         $display("Mismatch %s miss/valid flags expected %b actual %b", test_name,
                  $sampled(exp_flags), $sampled({imem_miss, if_valid0, if_valid1}));
      end

   a_instr : assert property (@(posedge clk) disable iff (!reset_n)
      resp_ready |-> {if_instr0, if_instr1} == {mem_word(if_pc0), mem_word(if_pc1)})
      else begin
         err_count++;
         $display("Mismatch %s instructions expected %h actual %h", test_name,
                  {mem_word($sampled(if_pc0)), mem_word($sampled(if_pc1))},
                  $sampled({if_instr0, if_instr1}));
      end

   a_ghsr : assert property (@(posedge clk) disable iff (!reset_n)
      if_ghsr0 == exp_ghsr && if_ghsr1 == exp_ghsr)
      else begin
         err_count++;
         $display("Mismatch %s ghsr expected %h actual %h", test_name,
                  $sampled({exp_ghsr, exp_ghsr}), $sampled({if_ghsr0, if_ghsr1}));
      end

   a_btb_slot0 : assert property (@(posedge clk) disable iff (!reset_n)
      track_valid && if_pc0 == track_addr |->
         if_btb_hit0 == track_hit && (!track_hit || if_btb_target0 == track_target))
      else begin
         err_count++;
         $display("Mismatch %s slot 0 btb expected %h actual %h", test_name,
                  $sampled({track_hit, track_target}),
                  $sampled({if_btb_hit0, if_btb_target0}));
      end

   a_btb_slot1 : assert property (@(posedge clk) disable iff (!reset_n)
      track_valid && if_pc1 == track_addr |->
         if_btb_hit1 == track_hit && (!track_hit || if_btb_target1 == track_target))
      else begin
         err_count++;
         $display("Mismatch %s slot 1 btb expected %h actual %h", test_name,
                  $sampled({track_hit, track_target}),
                  $sampled({if_btb_hit1, if_btb_target1}));
      end

   a_pred_taken : assert property (@(posedge clk) disable iff (!reset_n)
      pred_check && if_pc0 == track_addr && if_ghsr0 == TRAIN_GHSR |-> if_pred_taken0)
      else begin
         err_count++;
         $display("Mismatch %s pred_taken expected 1 actual %b", test_name,
                  $sampled(if_pred_taken0));
      end

   a_pred_taken1 : assert property (@(posedge clk) disable iff (!reset_n)
      pred_check && if_pc1 == track_addr && if_ghsr1 == TRAIN_GHSR |-> if_pred_taken1)
      else begin
         err_count++;
         $display("Mismatch %s slot 1 pred_taken expected 1 actual %b", test_name,
                  $sampled(if_pred_taken1));
      end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task automatic step();
      @(posedge clk);
      #1;                                           // Drive off the edge
   endtask

   task automatic run_cycles(input int n);
      repeat (n) step();
   endtask

   task automatic resolve_branch(input fetch_pkg::addr_t addr, input fetch_pkg::addr_t target,
                                 input logic taken, input fetch_pkg::ghsr_t ghsr);
      ex_branch_valid  = 1'b1;
      ex_branch_taken  = taken;
      ex_branch_addr   = addr;
      ex_branch_target = target;
      ex_branch_ghsr   = ghsr;
      step();
      ex_branch_valid  = 1'b0;                      // One-cycle strobe
   endtask

   task automatic redirect_to(input fetch_pkg::addr_t target);
      pc_flush         = 1'b1;
      ex_branch_target = target;
      step();
      pc_flush         = 1'b0;
   endtask

   task automatic begin_test(input string name);
      test_name    = name;
      err_at_start = err_count;
      tests_run++;
   endtask

   task automatic report_test();
      $display("%-16s done, %0d errors", test_name, err_count - err_at_start);
   endtask

   initial begin
      ex_branch_valid  = 1'b0;
      ex_branch_taken  = 1'b0;
      ex_branch_addr   = '0;
      ex_branch_target = '0;
      ex_branch_ghsr   = '0;
      pc_flush         = 1'b0;
      pc_stall         = 1'b0;
      force_ready      = 1'b0;
      track_valid      = 1'b0;
      track_hit        = 1'b0;
      track_addr       = '0;
      track_target     = '0;
      pred_check       = 1'b0;
      @(posedge reset_n);
      step();

      begin_test("reset_seq");
      run_cycles(20);                               // Empty BTB and straight-line fetch
      report_test();

      begin_test("mem_miss");
      run_cycles(30);
      report_test();

      begin_test("stall");
      pc_stall = 1'b1;
      run_cycles(5);
      pc_stall = 1'b0;
      run_cycles(3);
      pc_stall = 1'b1;                              // Single-cycle stall
      step();
      pc_stall = 1'b0;
      run_cycles(3);
      report_test();

      begin_test("train_redirect");
      force_ready = 1'b1;
      repeat (10) resolve_branch(BR_ADDR, BR_TARGET, 1'b1, TRAIN_GHSR); // Fills history too
      track_addr   = BR_ADDR;
      track_target = BR_TARGET;
      track_hit    = 1'b1;
      track_valid  = 1'b1;
      pred_check   = 1'b1;
      redirect_to(BR_ADDR);                         // Branch in slot 0
      run_cycles(3);
      redirect_to(BR_ADDR - 32'd4);                 // Branch in slot 1
      run_cycles(3);
      report_test();

      begin_test("flush");
      redirect_to(BR_ADDR);
      pc_stall = 1'b1;
      redirect_to(FL_TARGET);                       // Beats stall and taken hit
      run_cycles(2);
      redirect_to(BR_ADDR);                         // Lands while still stalled
      step();
      pc_stall = 1'b0;
      run_cycles(3);
      report_test();

      begin_test("btb_clear");
      pred_check = 1'b0;
      resolve_branch(BR_ADDR, BR_TARGET, 1'b0, TRAIN_GHSR);
      track_hit = 1'b0;
      redirect_to(BR_ADDR);
      run_cycles(2);
      redirect_to(BR_ADDR - 32'd4);
      run_cycles(2);
      force_ready = 1'b0;
      report_test();

      $display("Tests run %0d, failed checks %0d", tests_run, err_count);
      if (err_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- sources.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/pc_counter.sv
verilog/btb.sv
verilog/gshare.sv
verilog/if_stage.sv
test/tb_clock.sv
test/tb_if_stage.sv

//--- Makefile
VERILATOR  := verilator
TOP        := tb_if_stage
RTL_TOP    := if_stage
FILELIST   := sources.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint build sim clean

all: sim

# Design only, the testbench files are parsed but not elaborated
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The grep sets the exit status of the run
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
